// File: hdl/lane_insn_decoder.sv
// Lane instruction decoder
`timescale 1ns/1ps
`include "lane_seq_config.svh"

module lane_insn_decoder (
  input  logic [`LANE_ID_WIDTH-1:0]                         lane_id_i,
  input  lane_seq_pkg::pe_req_t                             req_i,
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  input  logic [lane_seq_pkg::NR_OPQ-1:0]                   opq_busy_i,
  input  logic [`NR_VINSN-1:0]                              vinsn_running_i,
  output lane_seq_pkg::opq_cmd_t [lane_seq_pkg::NR_OPQ-1:0] opq_cmd_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                   opq_push_o,
  output lane_seq_pkg::vfu_op_t                             vfu_op_o,
  output logic                                              vfu_op_valid_o,
  output logic                                              dispatch_o,
  output lane_seq_pkg::vid_t                                dispatch_id_o,
  output logic                                              dispatch_muted_o
);
  import lane_seq_pkg::*;
  import vector_isa_pkg::*;

  vlen_t              lane_vl;
  vlen_t              lane_vstart;
  vlen_t              st_vl;
  vlen_t              mask_vl;
  logic               unit_busy;
  logic               muted;
  logic [NR_OPQ-1:0]  push;

  // Builds the command of one operand, tagged with the current instruction
  function automatic opq_cmd_t make_cmd(vreg_t vs, vew_e eew, vlen_t vl, vinsn_vec_t hazard);
    opq_cmd_t cmd;
    cmd.id     = req_i.id;
    cmd.vs     = vs;
    cmd.eew    = eew;
    cmd.vl     = vl;
    cmd.vstart = lane_vstart;
    // Every operand also waits on the instruction that writes vd
    cmd.hazard = hazard | req_i.hazard_vd;
    return cmd;
  endfunction

  ////////////////////////////////////////////////////////////
  // Lane share of the vector
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Lanes below vl modulo the lane count run one extra element
    lane_vl = vlen_t'(req_i.vl / `NR_LANES);
    if (lane_id_i < req_i.vl % `NR_LANES)
      lane_vl = lane_vl + 1'b1;

    // The start index moves the other way
    lane_vstart = vlen_t'(req_i.vstart / `NR_LANES);
    if (lane_id_i < req_i.vstart % `NR_LANES)
      lane_vstart = lane_vstart - 1'b1;

    // The store unit gathers from all lanes, so every lane sends the rounded-up share
    st_vl = vlen_t'(req_i.vl / `NR_LANES);
    if (st_vl * `NR_LANES != req_i.vl)
      st_vl = st_vl + 1'b1;

    // Mask bits are packed 8 per byte across all lanes
    mask_vl = vlen_t'((req_i.vl / `NR_LANES / 8) >> int'(req_i.vsew));
    if ((mask_vl << int'(req_i.vsew)) * `NR_LANES * 8 != req_i.vl)
      mask_vl = mask_vl + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.vfu)
      VFU_ALU:   unit_busy = opq_busy_i[ALU_A] | opq_busy_i[ALU_B] | opq_busy_i[MASK_M];
      VFU_MFPU:  unit_busy = opq_busy_i[MFPU_A] | opq_busy_i[MFPU_B] |
                             opq_busy_i[MFPU_C] | opq_busy_i[MASK_M];
      VFU_STORE: unit_busy = opq_busy_i[ST_A] | opq_busy_i[MASK_M];
      default:   unit_busy = 1'b1;
    endcase
  end

  assign req_ready_o = !unit_busy && !vinsn_running_i[req_i.id];
  assign dispatch_o  = req_valid_i && req_ready_o;

  // Nothing to compute here, but the instruction still has to retire
  assign muted = (req_i.vfu inside {VFU_ALU, VFU_MFPU}) && (lane_vl == '0);

  assign dispatch_id_o    = req_i.id;
  assign dispatch_muted_o = dispatch_o && muted;
  assign vfu_op_valid_o   = dispatch_o && !muted;

  assign vfu_op_o = '{
    id:     req_i.id,
    vfu:    req_i.vfu,
    op:     req_i.op,
    vm:     req_i.vm,
    vd:     req_i.vd,
    vsew:   req_i.vsew,
    vl:     lane_vl,
    vstart: lane_vstart
  };

  ////////////////////////////////////////////////////////////
  // Operand commands
  ////////////////////////////////////////////////////////////

  always_comb begin
    opq_cmd_o = '0;
    push      = '0;

    case (req_i.vfu)
      VFU_ALU: begin
        opq_cmd_o[ALU_A] = make_cmd(req_i.vs1, req_i.eew_vs1, lane_vl, req_i.hazard_vs1);
        opq_cmd_o[ALU_B] = make_cmd(req_i.vs2, req_i.eew_vs2, lane_vl, req_i.hazard_vs2);
        push[ALU_A]      = req_i.use_vs1;
        push[ALU_B]      = req_i.use_vs2;
      end
      VFU_MFPU: begin
        opq_cmd_o[MFPU_A] = make_cmd(req_i.vs1, req_i.eew_vs1, lane_vl, req_i.hazard_vs1);
        push[MFPU_A]      = req_i.use_vs1;
        // The multiply-add forms read the addend through the B queue
        if (req_i.swap_vs2_vd_op) begin
          opq_cmd_o[MFPU_B] = make_cmd(req_i.vd, req_i.eew_vd_op, lane_vl, '0);
          opq_cmd_o[MFPU_C] = make_cmd(req_i.vs2, req_i.eew_vs2, lane_vl, req_i.hazard_vs2);
          push[MFPU_B]      = req_i.use_vd_op;
          push[MFPU_C]      = req_i.use_vs2;
        end else begin
          opq_cmd_o[MFPU_B] = make_cmd(req_i.vs2, req_i.eew_vs2, lane_vl, req_i.hazard_vs2);
          opq_cmd_o[MFPU_C] = make_cmd(req_i.vd, req_i.eew_vd_op, lane_vl, '0);
          push[MFPU_B]      = req_i.use_vs2;
          push[MFPU_C]      = req_i.use_vd_op;
        end
      end
      VFU_STORE: begin
        opq_cmd_o[ST_A] = make_cmd(req_i.vs1, req_i.eew_vs1, st_vl, req_i.hazard_vs1);
        push[ST_A]      = req_i.use_vs1;
      end
      default: begin
        push = '0;
      end
    endcase

    // All three units take the mask through the same queue
    opq_cmd_o[MASK_M] = make_cmd(VMASK, req_i.vsew, mask_vl, req_i.hazard_vm);
    push[MASK_M]      = !req_i.vm;
  end

  assign opq_push_o = push & {NR_OPQ{dispatch_o}};

endmodule

// File: hdl/lane_seq_config.svh
// Lane sequencer configuration
`ifndef LANE_SEQ_CONFIG_SVH
`define LANE_SEQ_CONFIG_SVH

////////////////////////////////////////////////////////////
// Lane geometry
////////////////////////////////////////////////////////////

// Number of lanes in the vector processor
`define NR_LANES 4

// Bits needed to name one lane
`define LANE_ID_WIDTH $clog2(`NR_LANES)

////////////////////////////////////////////////////////////
// Instruction bookkeeping
////////////////////////////////////////////////////////////

// Instruction IDs that can be in flight at the same time
`define NR_VINSN 8

// Width of the vl and vstart fields
`define VL_WIDTH 16

// Architectural vector registers
`define NR_VREGS 32

`endif

// File: hdl/lane_seq_pkg.sv
// Lane sequencer types
`include "lane_seq_config.svh"

package lane_seq_pkg;
  import vector_isa_pkg::*;

  ////////////////////////////////////////////////////////////
  // Operand queues
  ////////////////////////////////////////////////////////////

  localparam int unsigned NR_OPQ = 7;

  typedef enum logic [2:0] {
    ALU_A  = 3'd0,
    ALU_B  = 3'd1,
    MFPU_A = 3'd2,
    MFPU_B = 3'd3,
    MFPU_C = 3'd4,
    ST_A   = 3'd5,
    MASK_M = 3'd6
  } opq_e;

  ////////////////////////////////////////////////////////////
  // Common fields
  ////////////////////////////////////////////////////////////

  typedef logic [$clog2(`NR_VINSN)-1:0] vid_t;
  typedef logic [`VL_WIDTH-1:0]         vlen_t;
  // One bit per instruction ID
  typedef logic [`NR_VINSN-1:0]         vinsn_vec_t;

  // Request from the main sequencer
  typedef struct packed {
    vid_t       id;
    vfu_e       vfu;
    vop_e       op;
    logic       vm;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    logic       swap_vs2_vd_op;
    vreg_t      vs1;
    vreg_t      vs2;
    vreg_t      vd;
    vew_e       eew_vs1;
    vew_e       eew_vs2;
    vew_e       eew_vd_op;
    vew_e       vsew;
    vlen_t      vl;
    vlen_t      vstart;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vm;
    vinsn_vec_t hazard_vd;
  } pe_req_t;

  // Operation handed to the lane's functional units
  typedef struct packed {
    vid_t  id;
    vfu_e  vfu;
    vop_e  op;
    logic  vm;
    vreg_t vd;
    vew_e  vsew;
    vlen_t vl;
    vlen_t vstart;
  } vfu_op_t;

  // Command for one operand requester queue
  typedef struct packed {
    vid_t       id;
    vreg_t      vs;
    vew_e       eew;
    vlen_t      vl;
    vlen_t      vstart;
    vinsn_vec_t hazard;
  } opq_cmd_t;

  typedef struct packed {
    vinsn_vec_t vinsn_done;
  } pe_resp_t;

endpackage

// File: hdl/lane_sequencer.sv
// Lane sequencer
`timescale 1ns/1ps
`include "lane_seq_config.svh"

module lane_sequencer (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [`LANE_ID_WIDTH-1:0]                         lane_id_i,
  // Main sequencer side
  input  lane_seq_pkg::pe_req_t                             pe_req_i,
  input  logic                                              pe_req_valid_i,
  input  logic [`NR_VINSN-1:0]                              pe_vinsn_running_i,
  output logic                                              pe_req_ready_o,
  output lane_seq_pkg::pe_resp_t                            pe_resp_o,
  // Operand requester side
  output lane_seq_pkg::opq_cmd_t [lane_seq_pkg::NR_OPQ-1:0] operand_request_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                   operand_request_valid_o,
  input  logic [lane_seq_pkg::NR_OPQ-1:0]                   operand_request_ready_i,
  // Functional unit side
  output lane_seq_pkg::vfu_op_t                             vfu_operation_o,
  output logic                                              vfu_operation_valid_o,
  input  logic [`NR_VINSN-1:0]                              alu_vinsn_done_i,
  input  logic [`NR_VINSN-1:0]                              mfpu_vinsn_done_i,
  output logic                                              alu_vinsn_done_o,
  output logic                                              mfpu_vinsn_done_o
);
  import lane_seq_pkg::*;

  pe_req_t                 req;
  logic                    req_valid;
  logic                    req_ready;
  opq_cmd_t [NR_OPQ-1:0]   opq_cmd;
  logic     [NR_OPQ-1:0]   opq_push;
  vfu_op_t                 vfu_op;
  logic                    vfu_op_valid;
  logic                    dispatch;
  vid_t                    dispatch_id;
  logic                    dispatch_muted;
  logic [`NR_VINSN-1:0]    vinsn_running;

  pe_req_register #(
    .T(pe_req_t)
  ) i_req_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (pe_req_i),
    .valid_i(pe_req_valid_i),
    .ready_o(pe_req_ready_o),
    .data_o (req),
    .valid_o(req_valid),
    .ready_i(req_ready)
  );

  lane_insn_decoder i_decoder (
    .lane_id_i       (lane_id_i),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .opq_busy_i      (operand_request_valid_o),
    .vinsn_running_i (vinsn_running),
    .opq_cmd_o       (opq_cmd),
    .opq_push_o      (opq_push),
    .vfu_op_o        (vfu_op),
    .vfu_op_valid_o  (vfu_op_valid),
    .dispatch_o      (dispatch),
    .dispatch_id_o   (dispatch_id),
    .dispatch_muted_o(dispatch_muted)
  );

  operand_cmd_slots i_slots (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (opq_cmd),
    .push_i (opq_push),
    .cmd_o  (operand_request_o),
    .valid_o(operand_request_valid_o),
    .ready_i(operand_request_ready_i)
  );

  vinsn_tracker i_tracker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pe_vinsn_running_i(pe_vinsn_running_i),
    .dispatch_i        (dispatch),
    .dispatch_id_i     (dispatch_id),
    .dispatch_muted_i  (dispatch_muted),
    .alu_done_i        (alu_vinsn_done_i),
    .mfpu_done_i       (mfpu_vinsn_done_i),
    .vinsn_running_o   (vinsn_running),
    .pe_resp_o         (pe_resp_o),
    .alu_vinsn_done_o  (alu_vinsn_done_o),
    .mfpu_vinsn_done_o (mfpu_vinsn_done_o)
  );

  ////////////////////////////////////////////////////////////
  // Operation register towards the functional units
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_operation_valid_o <= 1'b0;
    end else begin
      vfu_operation_valid_o <= vfu_op_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (vfu_op_valid) begin
      vfu_operation_o <= vfu_op;
    end
  end

endmodule

// File: hdl/operand_cmd_slots.sv
// Operand command slots
`timescale 1ns/1ps

module operand_cmd_slots (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  lane_seq_pkg::opq_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd_i,
  input  logic [lane_seq_pkg::NR_OPQ-1:0]                   push_i,
  output lane_seq_pkg::opq_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                   valid_o,
  input  logic [lane_seq_pkg::NR_OPQ-1:0]                   ready_i
);
  import lane_seq_pkg::*;

  ////////////////////////////////////////////////////////////
  // Slot occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      for (int q = 0; q < NR_OPQ; q++) begin
        // A new command wins over the requester taking the old one
        if (push_i[q]) begin
          valid_o[q] <= 1'b1;
        end else if (ready_i[q]) begin
          valid_o[q] <= 1'b0;
        end
      end
    end
  end

  // Slot contents only change when a command is pushed
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NR_OPQ; q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end
    end
  end

endmodule

// File: hdl/pe_req_register.sv
// Fall-through request register
`timescale 1ns/1ps

module pe_req_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  logic full_q;
  T     data_q;

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  // An empty register is transparent, a full one presents the held entry
  assign data_o  = full_q ? data_q : data_i;
  assign valid_o = full_q | valid_i;

  // Only an empty register takes a new entry
  assign ready_o = !full_q;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // The held entry leaves once the consumer takes it
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (valid_i && !ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Capture the input when it passed through but was not consumed
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

// File: hdl/vector_isa_pkg.sv
// Vector instruction set types
`include "lane_seq_config.svh"

package vector_isa_pkg;

  // Functional unit that executes an instruction in the lane
  typedef enum logic [1:0] {
    VFU_ALU   = 2'd0,
    VFU_MFPU  = 2'd1,
    VFU_STORE = 2'd2
  } vfu_e;

  // Opcodes kept by this lane
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VMUL   = 3'd2,
    VMACC  = 3'd3,
    VSTORE = 3'd4
  } vop_e;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector register index
  typedef logic [$clog2(`NR_VREGS)-1:0] vreg_t;

  // The mask always lives in v0
  localparam vreg_t VMASK = '0;

endpackage

// File: hdl/vinsn_tracker.sv
// Running instruction tracker
`timescale 1ns/1ps
`include "lane_seq_config.svh"

module vinsn_tracker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`NR_VINSN-1:0]   pe_vinsn_running_i,
  input  logic                   dispatch_i,
  input  lane_seq_pkg::vid_t     dispatch_id_i,
  input  logic                   dispatch_muted_i,
  input  logic [`NR_VINSN-1:0]   alu_done_i,
  input  logic [`NR_VINSN-1:0]   mfpu_done_i,
  output logic [`NR_VINSN-1:0]   vinsn_running_o,
  output lane_seq_pkg::pe_resp_t pe_resp_o,
  output logic                   alu_vinsn_done_o,
  output logic                   mfpu_vinsn_done_o
);

  logic [`NR_VINSN-1:0] running_q;
  logic [`NR_VINSN-1:0] running_d;
  logic [`NR_VINSN-1:0] done_d;

  // The main sequencer retires IDs by dropping them from its own vector
  assign vinsn_running_o = running_q & pe_vinsn_running_i;

  always_comb begin
    running_d = vinsn_running_o;
    done_d    = alu_done_i | mfpu_done_i;

    // A muted instruction finishes in this lane on the cycle it is dispatched
    if (dispatch_i) begin
      if (dispatch_muted_i)
        done_d[dispatch_id_i] = 1'b1;
      else
        running_d[dispatch_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q         <= '0;
      pe_resp_o         <= '0;
      alu_vinsn_done_o  <= 1'b0;
      mfpu_vinsn_done_o <= 1'b0;
    end else begin
      running_q            <= running_d;
      pe_resp_o.vinsn_done <= done_d;
      alu_vinsn_done_o     <= |alu_done_i;
      mfpu_vinsn_done_o    <= |mfpu_done_i;
    end
  end

endmodule

// File: project.f
+incdir+hdl
+incdir+testbench
hdl/vector_isa_pkg.sv
hdl/lane_seq_pkg.sv
hdl/pe_req_register.sv
hdl/lane_insn_decoder.sv
hdl/operand_cmd_slots.sv
hdl/vinsn_tracker.sv
hdl/lane_sequencer.sv
testbench/tb_lane_sequencer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lane sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_lane_sequencer -o tb_lane_sequencer_sim

out=$(./obj_dir/tb_lane_sequencer_sim 2>&1) || true
echo "$out"

echo "$out" | grep -q "^Test passed$"

// File: testbench/tb_lane_seq_model.svh
// Lane split reference model
`ifndef TB_LANE_SEQ_MODEL_SVH
`define TB_LANE_SEQ_MODEL_SVH

////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////

// Next state of the linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////////////////////////////////////////////
// Lane share of a vector instruction
////////////////////////////////////////////////////////////

// Elements handled by this lane
function automatic int lane_share(input int vl, input int lanes, input int lane_id);
  int share;
  share = vl / lanes;
  if (lane_id < (vl % lanes))
    share = share + 1;
  return share;
endfunction

// First element index inside this lane
function automatic int lane_start(input int vstart, input int lanes, input int lane_id);
  int start;
  start = vstart / lanes;
  if (lane_id < (vstart % lanes))
    start = start - 1;
  return start;
endfunction

// Store operand length, the lane share rounded up
function automatic int store_share(input int vl, input int lanes);
  int share;
  share = vl / lanes;
  if (share * lanes != vl)
    share = share + 1;
  return share;
endfunction

// Mask operand length, eight mask bits per byte spread over all lanes
function automatic int mask_length(input int vl, input int lanes, input int vsew);
  int q;
  q = (vl / lanes / 8) >> vsew;
  if (((q << vsew) * lanes * 8) != vl)
    q = q + 1;
  return q;
endfunction

`endif

// File: testbench/tb_lane_sequencer.sv
// Lane sequencer testbench
`timescale 1ns/1ps
`include "lane_seq_config.svh"

module tb_lane_sequencer;
  import lane_seq_pkg::*;
  import vector_isa_pkg::*;

  `include "tb_lane_seq_model.svh"

  localparam int LANE = 1;
  localparam int TIMEOUT = 50;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic [`LANE_ID_WIDTH-1:0] lane_id_i;
  pe_req_t                pe_req_i;
  logic                   pe_req_valid_i;
  logic [`NR_VINSN-1:0]   pe_vinsn_running_i;
  logic                   pe_req_ready_o;
  pe_resp_t               pe_resp_o;
  opq_cmd_t [NR_OPQ-1:0]  operand_request_o;
  logic [NR_OPQ-1:0]      operand_request_valid_o;
  logic [NR_OPQ-1:0]      operand_request_ready_i;
  vfu_op_t                vfu_operation_o;
  logic                   vfu_operation_valid_o;
  logic [`NR_VINSN-1:0]   alu_vinsn_done_i;
  logic [`NR_VINSN-1:0]   mfpu_vinsn_done_i;
  logic                   alu_vinsn_done_o;
  logic                   mfpu_vinsn_done_o;

  logic [31:0] lcg_state = 32'hbfd9d6b4;
  pe_req_t     r1;
  pe_req_t     r2;
  int          vl;

  lane_sequencer dut0 (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else
      stop_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_random(input int range, output int value);
    lcg_state = lcg_step(lcg_state);
    value = int'(lcg_state[30:8] % range);
  endtask

  // Builds a request with random registers
  task automatic build_request(input int id, input vfu_e vfu, input int req_vl,
                               output pe_req_t r);
    int v;
    r = '0;
    r.id = vid_t'(id);
    r.vfu = vfu;
    r.op = (vfu == VFU_STORE) ? VSTORE : VADD;
    r.vm = 1'b1;
    r.use_vs1 = 1'b1;
    r.use_vs2 = 1'b1;
    r.vsew = EW32;
    r.vl = vlen_t'(req_vl);
    next_random(64, v);
    r.vstart = vlen_t'(v);
    next_random(32, v);
    r.vs1 = vreg_t'(v);
    next_random(32, v);
    r.vs2 = vreg_t'(v);
    next_random(32, v);
    r.vd = vreg_t'(v);
  endtask

  // Called just after a rising edge; returns once the register has taken the request
  task automatic send_request(input pe_req_t r);
    int  cycles;
    logic taken;
    cycles = 0;
    taken = 1'b0;
    pe_req_i = r;
    pe_req_valid_i = 1'b1;
    while (!taken) begin
      @(negedge clk_i);
      taken = pe_req_ready_o;
      cycles++;
      if (cycles > TIMEOUT)
        stop_run("request was never accepted by the lane sequencer");
    end
    @(posedge clk_i);
    #2;
    pe_req_valid_i = 1'b0;
  endtask

  // Ends on the falling edge where the registered operation is visible
  task automatic wait_vfu_op;
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!vfu_operation_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT)
        stop_run("no vfu operation was issued");
      @(negedge clk_i);
    end
  endtask

  task automatic wait_done_bit(input int id);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!pe_resp_o.vinsn_done[id]) begin
      assert (!vfu_operation_valid_o) else stop_run("muted operation reached the units");
      cycles++;
      if (cycles > TIMEOUT)
        stop_run("done bit of the muted instruction never appeared");
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    lane_id_i = LANE;
    pe_req_i = '0;
    pe_req_valid_i = 1'b0;
    pe_vinsn_running_i = '1;
    operand_request_ready_i = '1;
    alu_vinsn_done_i = '0;
    mfpu_vinsn_done_i = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    check_value("reset vfu valid", 0, vfu_operation_valid_o);
    check_value("reset opq valid", 0, operand_request_valid_o);
    check_value("reset alu done", 0, alu_vinsn_done_o);
    check_value("reset mfpu done", 0, mfpu_vinsn_done_o);
    check_value("reset resp", 0, pe_resp_o.vinsn_done);
    check_value("reset ready", 1, pe_req_ready_o);
    @(posedge clk_i);
    #2;

    // Unmasked ALU operation
    next_random(300, vl);
    build_request(0, VFU_ALU, vl + 5, r1);
    send_request(r1);
    wait_vfu_op();
    check_value("alu vl", lane_share(r1.vl, `NR_LANES, LANE), vfu_operation_o.vl);
    // The start index wraps at the field width
    check_value("alu vstart", vlen_t'(lane_start(r1.vstart, `NR_LANES, LANE)),
                vfu_operation_o.vstart);
    check_value("alu id", 0, vfu_operation_o.id);
    check_value("alu vd", r1.vd, vfu_operation_o.vd);
    check_value("alu vsew", int'(EW32), int'(vfu_operation_o.vsew));
    check_value("alu_a vl", lane_share(r1.vl, `NR_LANES, LANE), operand_request_o[ALU_A].vl);
    check_value("alu_b vl", lane_share(r1.vl, `NR_LANES, LANE), operand_request_o[ALU_B].vl);
    check_value("alu_a vs", r1.vs1, operand_request_o[ALU_A].vs);
    check_value("alu mask push", 0, operand_request_valid_o[MASK_M]);
    @(posedge clk_i);
    #2;

    // Masked multiply-add with vs2/vd swap
    next_random(300, vl);
    build_request(1, VFU_MFPU, vl + 5, r1);
    r1.op = VMACC;
    r1.vm = 1'b0;
    r1.use_vd_op = 1'b1;
    r1.swap_vs2_vd_op = 1'b1;
    send_request(r1);
    wait_vfu_op();
    check_value("mfpu_b vs", r1.vd, operand_request_o[MFPU_B].vs);
    check_value("mfpu_c vs", r1.vs2, operand_request_o[MFPU_C].vs);
    check_value("mfpu mask valid", 1, operand_request_valid_o[MASK_M]);
    check_value("mfpu mask vl", mask_length(r1.vl, `NR_LANES, int'(r1.vsew)),
                operand_request_o[MASK_M].vl);
    @(posedge clk_i);
    #2;

    // Masked store
    next_random(300, vl);
    build_request(2, VFU_STORE, vl + 5, r1);
    r1.vm = 1'b0;
    send_request(r1);
    wait_vfu_op();
    check_value("store unit", int'(VFU_STORE), int'(vfu_operation_o.vfu));
    check_value("st_a valid", 1, operand_request_valid_o[ST_A]);
    check_value("st_a vl", store_share(r1.vl, `NR_LANES), operand_request_o[ST_A].vl);
    check_value("store mask valid", 1, operand_request_valid_o[MASK_M]);
    @(posedge clk_i);
    #2;

    // Muted ALU operation and unit done forwarding
    build_request(3, VFU_ALU, 1, r1);
    send_request(r1);
    wait_done_bit(3);
    check_value("muted vfu valid", 0, vfu_operation_valid_o);
    @(posedge clk_i);
    #2;
    mfpu_vinsn_done_i = 8'b0001_0000;
    @(posedge clk_i);
    #2;
    mfpu_vinsn_done_i = '0;
    @(negedge clk_i);
    check_value("mfpu done out", 1, mfpu_vinsn_done_o);
    check_value("mfpu done alu out", 0, alu_vinsn_done_o);
    check_value("mfpu done resp", 8'b0001_0000, pe_resp_o.vinsn_done);
    @(posedge clk_i);
    #2;
    alu_vinsn_done_i = 8'b0000_0100;
    @(posedge clk_i);
    #2;
    alu_vinsn_done_i = '0;
    @(negedge clk_i);
    check_value("alu done out", 1, alu_vinsn_done_o);
    check_value("alu done mfpu out", 0, mfpu_vinsn_done_o);
    check_value("alu done resp", 8'b0000_0100, pe_resp_o.vinsn_done);
    @(posedge clk_i);
    #2;

    // Back-pressure on ALU_A
    operand_request_ready_i = 7'b111_1110;
    build_request(5, VFU_ALU, 40, r1);
    build_request(6, VFU_ALU, 48, r2);
    send_request(r1);
    wait_vfu_op();
    check_value("first id", 5, vfu_operation_o.id);
    @(posedge clk_i);
    #2;
    send_request(r2);
    repeat (3) begin
      @(negedge clk_i);
      check_value("stall ready", 0, pe_req_ready_o);
      check_value("stall alu_a id", 5, operand_request_o[ALU_A].id);
      check_value("stall alu_a vs", r1.vs1, operand_request_o[ALU_A].vs);
      check_value("stall vfu valid", 0, vfu_operation_valid_o);
    end
    @(posedge clk_i);
    #2;
    operand_request_ready_i = '1;
    wait_vfu_op();
    check_value("second id", 6, vfu_operation_o.id);
    check_value("second alu_a id", 6, operand_request_o[ALU_A].id);
    check_value("second vl", lane_share(48, `NR_LANES, LANE), vfu_operation_o.vl);

    repeat (2) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

endmodule
